//--- hdl/rv_pkg.sv
// ======================================================================
// RV32I subset only. No CSR, no traps, word-wide memory access.
// AXI4-Lite response codes are not carried, so bus errors go unseen.
// ======================================================================
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes that the core executes
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef struct packed {
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;       // already sign extended
        logic [2:0] funct3;
        alu_op_t    alu_op;
        logic       use_imm;   // operand b from imm instead of rs2
        logic       use_pc;    // operand a from pc
        logic       zero_a;    // operand a forced to zero (lui)
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       is_load;
        logic       is_store;
        logic       writes_rd;
    } decoded_t;

    // master side of the bus
    typedef struct packed {
        word_t             araddr;
        logic              arvalid;
        logic              rready;
        word_t             awaddr;
        logic              awvalid;
        word_t             wdata;
        logic [xlen/8-1:0] wstrb;
        logic              wvalid;
        logic              bready;
    } axil_req_t;

    typedef struct packed {
        logic  arready;
        word_t rdata;
        logic  rvalid;
        logic  awready;
        logic  wready;
        logic  bvalid;
    } axil_resp_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;  // 1 = store
    } mem_req_t;

endpackage

//--- hdl/rv_regfile.sv
// ======================================================================
// 32 x 32 registers, x0 hard-wired to zero.
// ======================================================================
module rv_regfile (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  logic             we,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;  // x0 writes dropped
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- hdl/rv_decode.sv
// ======================================================================
// Unknown opcodes decode to a no-op: no write, no memory, no jump.
// ======================================================================
module rv_decode (
    input  rv_pkg::word_t    ir,
    output rv_pkg::decoded_t dec
);
    import rv_pkg::*;

    opcode_t    opc;
    logic [6:0] funct7;
    alu_op_t    arith_op;

    assign opc    = opcode_t'(ir[6:0]);
    assign funct7 = ir[31:25];

    // funct3/funct7 to ALU op, shared by OP and OP-IMM
    always_comb begin
        case (ir[14:12])
            3'b000:  arith_op = (opc == opc_op && funct7[5]) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = funct7[5] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        dec        = '0;
        dec.rd     = ir[11:7];
        dec.rs1    = ir[19:15];
        dec.rs2    = ir[24:20];
        dec.funct3 = ir[14:12];
        dec.alu_op = alu_add;
        case (opc)
            opc_op: begin
                dec.alu_op    = arith_op;
                dec.writes_rd = 1'b1;
            end
            opc_op_imm: begin
                dec.imm       = {{20{ir[31]}}, ir[31:20]};
                dec.alu_op    = arith_op;
                dec.use_imm   = 1'b1;
                dec.writes_rd = 1'b1;
            end
            opc_load, opc_jalr: begin
                dec.imm       = {{20{ir[31]}}, ir[31:20]};
                dec.use_imm   = 1'b1;
                dec.is_load   = (opc == opc_load);
                dec.is_jalr   = (opc == opc_jalr);
                dec.writes_rd = 1'b1;
            end
            opc_store: begin
                dec.imm      = {{20{ir[31]}}, ir[31:25], ir[11:7]};
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            opc_branch: begin  // alu forms the target, compare is separate
                dec.imm       = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
                dec.use_imm   = 1'b1;
                dec.use_pc    = 1'b1;
                dec.is_branch = 1'b1;
            end
            opc_jal: begin
                dec.imm       = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
                dec.use_imm   = 1'b1;
                dec.use_pc    = 1'b1;
                dec.is_jal    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            opc_lui, opc_auipc: begin
                dec.imm       = {ir[31:12], 12'b0};
                dec.use_imm   = 1'b1;
                dec.zero_a    = (opc == opc_lui);
                dec.use_pc    = (opc == opc_auipc);
                dec.writes_rd = 1'b1;
            end
            default: ;  // retires as a no-op
        endcase
    end

endmodule

//--- hdl/rv_execute.sv
// ======================================================================
// Purely combinational. Also picks the register write value.
// ======================================================================
module rv_execute (
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    rdata1,
    input  rv_pkg::word_t    rdata2,
    output rv_pkg::word_t    mem_addr,
    output rv_pkg::word_t    store_data,
    output rv_pkg::word_t    next_pc,
    output rv_pkg::word_t    wb_data
);
    import rv_pkg::*;

    word_t      op_a, op_b, alu_res, pc_plus4;
    logic [4:0] shamt;
    logic       taken;

    assign pc_plus4 = pc + 32'd4;
    assign shamt    = op_b[4:0];

    always_comb begin
        if (dec.zero_a)
            op_a = '0;
        else if (dec.use_pc)
            op_a = pc;
        else
            op_a = rdata1;
        op_b = dec.use_imm ? dec.imm : rdata2;
    end

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_res = op_a + op_b;
            alu_sub:  alu_res = op_a - op_b;
            alu_sll:  alu_res = op_a << shamt;
            alu_slt:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_res = {31'b0, op_a < op_b};
            alu_xor:  alu_res = op_a ^ op_b;
            alu_srl:  alu_res = op_a >> shamt;
            alu_sra:  alu_res = $unsigned($signed(op_a) >>> shamt);
            alu_or:   alu_res = op_a | op_b;
            alu_and:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    // branch compare always on the two register values
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rdata1 == rdata2);
            3'b001:  taken = (rdata1 != rdata2);
            3'b100:  taken = ($signed(rdata1) < $signed(rdata2));
            3'b101:  taken = ($signed(rdata1) >= $signed(rdata2));
            3'b110:  taken = (rdata1 < rdata2);
            3'b111:  taken = (rdata1 >= rdata2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (dec.is_jalr)
            next_pc = {alu_res[31:1], 1'b0};
        else if (dec.is_jal || (dec.is_branch && taken))
            next_pc = alu_res;  // pc + imm
        else
            next_pc = pc_plus4;
    end

    assign wb_data    = (dec.is_jal || dec.is_jalr) ? pc_plus4 : alu_res;  // link value
    assign mem_addr   = alu_res;
    assign store_data = rdata2;

endmodule

//--- hdl/axil_port.sv
// ======================================================================
// One AXI4-Lite transaction at a time. wstrb fixed to all ones,
// rresp and bresp are not looked at.
// ======================================================================
module axil_port (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_valid,
    input  rv_pkg::mem_req_t   mem_req,
    output logic               mem_ready,
    output logic               mem_done,
    output rv_pkg::word_t      mem_rdata,
    output rv_pkg::axil_req_t  axil_req,
    input  rv_pkg::axil_resp_t axil_resp
);
    import rv_pkg::*;

    typedef enum logic [2:0] {st_idle, st_ar, st_r, st_aw_w, st_b} state_t;

    state_t state;
    word_t  addr, wdata;
    logic   aw_pend, w_pend;  // AW and W complete independently
    logic   aw_ok, w_ok;

    assign mem_ready = (state == st_idle);
    assign aw_ok     = !aw_pend || axil_resp.awready;
    assign w_ok      = !w_pend || axil_resp.wready;

    always_comb begin
        axil_req         = '0;
        axil_req.araddr  = addr;
        axil_req.arvalid = (state == st_ar);
        axil_req.rready  = (state == st_r);
        axil_req.awaddr  = addr;
        axil_req.awvalid = aw_pend;
        axil_req.wdata   = wdata;
        axil_req.wstrb   = '1;
        axil_req.wvalid  = w_pend;
        axil_req.bready  = (state == st_b);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= st_idle;
            aw_pend  <= 1'b0;
            w_pend   <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;  // single-cycle pulse
            case (state)
                st_idle: begin
                    if (mem_valid) begin
                        state   <= mem_req.write ? st_aw_w : st_ar;
                        aw_pend <= mem_req.write;
                        w_pend  <= mem_req.write;
                    end
                end
                st_ar:   if (axil_resp.arready) state <= st_r;
                st_r: begin
                    if (axil_resp.rvalid) begin
                        mem_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                st_aw_w: begin
                    if (axil_resp.awready)
                        aw_pend <= 1'b0;
                    if (axil_resp.wready)
                        w_pend <= 1'b0;
                    if (aw_ok && w_ok)
                        state <= st_b;
                end
                st_b: begin
                    if (axil_resp.bvalid) begin
                        mem_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && mem_valid) begin
            addr  <= mem_req.addr;
            wdata <= mem_req.wdata;
        end
        if (state == st_r && axil_resp.rvalid)
            mem_rdata <= axil_resp.rdata;
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        axil_req.arvalid && !axil_resp.arready |=>
            axil_req.arvalid && $stable(axil_req.araddr));
    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        axil_req.awvalid && !axil_resp.awready |=>
            axil_req.awvalid && $stable(axil_req.awaddr));

endmodule

//--- hdl/rv_ctrl.sv
// ======================================================================
// Sequencer: fetch, execute, then memory for loads and stores only.
// ======================================================================
module rv_ctrl #(
    parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::word_t    mem_addr,
    input  rv_pkg::word_t    store_data,
    input  rv_pkg::word_t    next_pc,
    input  rv_pkg::word_t    wb_data,
    input  logic             mem_ready,
    input  logic             mem_done,
    input  rv_pkg::word_t    mem_rdata,
    output logic             mem_valid,
    output rv_pkg::mem_req_t mem_req,
    output rv_pkg::word_t    ir,
    output rv_pkg::word_t    pc,
    output logic             rd_we,
    output rv_pkg::word_t    rd_wdata,
    output logic             retire
);
    import rv_pkg::*;

    typedef enum logic [1:0] {st_fetch, st_exec, st_mem} state_t;

    state_t state;
    logic   sent;    // bus request already handed over in this phase
    logic   is_mem;

    assign is_mem    = dec.is_load | dec.is_store;
    assign mem_valid = (state == st_fetch || state == st_mem) && !sent;

    always_comb begin
        mem_req = '0;
        if (state == st_mem) begin
            mem_req.addr  = mem_addr;
            mem_req.wdata = store_data;
            mem_req.write = dec.is_store;
        end else begin
            mem_req.addr = pc;  // instruction fetch
        end
    end

    assign retire   = (state == st_exec && !is_mem) || (state == st_mem && mem_done);
    assign rd_we    = retire && dec.writes_rd;
    assign rd_wdata = dec.is_load ? mem_rdata : wb_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_fetch;
            sent  <= 1'b0;
            pc    <= reset_pc;
        end else begin
            if (mem_valid && mem_ready)
                sent <= 1'b1;
            case (state)
                st_fetch: begin
                    if (mem_done) begin
                        sent  <= 1'b0;
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    if (is_mem) begin
                        state <= st_mem;
                    end else begin
                        pc    <= next_pc;
                        state <= st_fetch;
                    end
                end
                st_mem: begin
                    if (mem_done) begin
                        sent  <= 1'b0;
                        pc    <= next_pc;
                        state <= st_fetch;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && mem_done)
            ir <= mem_rdata;
    end

    // an instruction retires only once its bus traffic is over
    a_retire_no_req: assert property (@(posedge clk) disable iff (reset)
        !(retire && mem_valid));

endmodule

//--- hdl/rv_core.sv
// ======================================================================
// Multi-cycle core, one instruction in flight, one AXI4-Lite master.
// ======================================================================
module rv_core #(
    parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               reset,
    output rv_pkg::axil_req_t  m_axil_req,
    input  rv_pkg::axil_resp_t m_axil_resp,
    output logic               retire
);
    import rv_pkg::*;

    decoded_t dec;
    mem_req_t mem_req;
    word_t    ir, pc;
    word_t    mem_addr, store_data, next_pc, wb_data;
    word_t    mem_rdata, rd_wdata;
    word_t    rdata1, rdata2;
    logic     mem_valid, mem_ready, mem_done;
    logic     rd_we;

    rv_ctrl #(.reset_pc(reset_pc)) u_ctrl (
        .clk(clk), .reset(reset), .dec(dec),
        .mem_addr(mem_addr), .store_data(store_data), .next_pc(next_pc), .wb_data(wb_data),
        .mem_ready(mem_ready), .mem_done(mem_done), .mem_rdata(mem_rdata),
        .mem_valid(mem_valid), .mem_req(mem_req), .ir(ir), .pc(pc),
        .rd_we(rd_we), .rd_wdata(rd_wdata), .retire(retire)
    );

    axil_port u_port (
        .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_req(mem_req),
        .mem_ready(mem_ready), .mem_done(mem_done), .mem_rdata(mem_rdata),
        .axil_req(m_axil_req), .axil_resp(m_axil_resp)
    );

    rv_decode u_decode (.ir(ir), .dec(dec));

    rv_regfile u_regfile (
        .clk(clk), .reset(reset), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .we(rd_we), .wdata(rd_wdata), .rdata1(rdata1), .rdata2(rdata2)
    );

    rv_execute u_execute (
        .dec(dec), .pc(pc), .rdata1(rdata1), .rdata2(rdata2),
        .mem_addr(mem_addr), .store_data(store_data), .next_pc(next_pc), .wb_data(wb_data)
    );

endmodule

//--- bench/tb_axil_mem.sv
// ======================================================================
// AXI4-Lite slave memory, word access only, one read and one write
// in flight at most. Ready and valid delays come from $urandom.
// ======================================================================
module tb_axil_mem #(
    parameter int depth        = 512,
    parameter bit random_delay = 1
) (
    input  logic               clk,
    input  rv_pkg::axil_req_t  req,
    output rv_pkg::axil_resp_t resp,
    output logic               st_ev,    // one-cycle pulse per completed write
    output rv_pkg::word_t      st_addr,
    output rv_pkg::word_t      st_data
);
    import rv_pkg::*;

    word_t mem [depth];
    word_t rd_word, aw_addr, w_data;
    logic  rd_pend, aw_got, w_got, b_pend;
    logic  r_done, b_done;

    function automatic logic ready_now();
        if (!random_delay)
            return 1'b1;
        return ($urandom % 3) != 0;
    endfunction

    function automatic int word_index(input word_t addr);
        return int'(addr[31:2]) % depth;
    endfunction

    initial begin
        for (int i = 0; i < depth; i++)
            mem[i] = word_t'(i * 4) ^ 32'hA5C3_5A3C;  // unwritten words are recognizable
        resp    = '0;
        st_ev   = 1'b0;
        st_addr = '0;
        st_data = '0;
        rd_pend = 1'b0;
        aw_got  = 1'b0;
        w_got   = 1'b0;
        b_pend  = 1'b0;
    end

    always @(posedge clk) begin
        // handshakes as seen at the edge
        r_done = resp.rvalid && req.rready;
        b_done = resp.bvalid && req.bready;
        if (req.arvalid && resp.arready) begin
            rd_word = mem[word_index(req.araddr)];
            rd_pend = 1'b1;
        end
        if (req.awvalid && resp.awready) begin
            aw_addr = req.awaddr;
            aw_got  = 1'b1;
        end
        if (req.wvalid && resp.wready) begin
            w_data = req.wdata;
            w_got  = 1'b1;
        end
        #1;
        st_ev = 1'b0;
        if (r_done)
            resp.rvalid = 1'b0;
        if (b_done)
            resp.bvalid = 1'b0;
        if (rd_pend && ready_now()) begin
            resp.rvalid = 1'b1;
            resp.rdata  = rd_word;
            rd_pend     = 1'b0;
        end
        if (aw_got && w_got) begin
            mem[word_index(aw_addr)] = w_data;
            st_ev   = 1'b1;
            st_addr = aw_addr;
            st_data = w_data;
            aw_got  = 1'b0;
            w_got   = 1'b0;
            b_pend  = 1'b1;
        end
        if (b_pend && ready_now()) begin
            resp.bvalid = 1'b1;
            b_pend      = 1'b0;
        end
        resp.arready = req.arvalid && !rd_pend && ready_now();
        resp.awready = req.awvalid && !aw_got && ready_now();
        resp.wready  = req.wvalid && !w_got && ready_now();
    end

endmodule

//--- bench/tb_rv_core.sv
// ======================================================================
// Program runs from address 0. Data lives at 0x400 and above, so any
// read below 0x400 counts as an instruction fetch.
// ======================================================================
module tb_rv_core;
    import rv_pkg::*;

    localparam word_t reset_pc = 32'h0000_0000;

    typedef struct packed {
        word_t      addr;
        word_t      data;
        logic [2:0] test;
    } store_t;

    logic       clk;
    logic       reset;
    logic       rst_d;
    logic       retire;
    logic       seen_ar;
    axil_req_t  m_axil_req;
    axil_resp_t m_axil_resp;
    logic       st_ev;
    word_t      st_addr, st_data;

    word_t  prog[$];
    word_t  fetch_exp[$];
    store_t store_exp[$];
    word_t  pc_next;
    int     errors[5];
    int     n_exec, fetch_count, retire_count, cycles, limit, marker, step;
    int     total, failed;
    string  names[5] = '{"reset", "alu", "control flow", "load/store", "back-pressure"};

    rv_core #(.reset_pc(reset_pc)) dut0 (
        .clk(clk), .reset(reset), .m_axil_req(m_axil_req),
        .m_axil_resp(m_axil_resp), .retire(retire)
    );

    tb_axil_mem #(.depth(512), .random_delay(1)) mem0 (
        .clk(clk), .req(m_axil_req), .resp(m_axil_resp),
        .st_ev(st_ev), .st_addr(st_addr), .st_data(st_data)
    );

    always #5 clk = ~clk;

    // RV32I encoders
    function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(input int imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        word_t v;
        v = imm;
        return {v[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input int imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
        word_t v;
        v = imm;
        return {v[11:5], rs2, rs1, 3'b010, v[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input int off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        word_t v;
        v = off;
        return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [19:0] upper, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {upper, rd, opc};
    endfunction

    function automatic word_t j_type(input int off, input logic [4:0] rd);
        word_t v;
        v = off;
        return {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
    endfunction

    task automatic place(input word_t instr, input logic runs);
        prog.push_back(instr);
        if (runs)
            fetch_exp.push_back(pc_next);
        pc_next += 4;
    endtask

    task automatic store_word(input logic [4:0] rs2, input int addr, input word_t value,
                              input logic [2:0] test);
        store_t e;
        e.addr = addr;
        e.data = value;
        e.test = test;
        place(s_type(addr, rs2, 5'd0), 1'b1);
        store_exp.push_back(e);
    endtask

    // branch then an addi on x20 that only runs when not taken
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic taken);
        step++;
        place(b_type(8, rs2, rs1, f3), 1'b1);
        place(i_type(step, 20, 3'b000, 20, 7'b0010011), !taken);
        if (!taken)
            marker += step;
    endtask

    task automatic build_program();
        word_t      p;
        logic [2:0] f3s [6];
        logic       tk_ab [6];
        logic       tk_ba [6];
        f3s   = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        // x2 = -7 and x3 = 5: signed x2 < x3, unsigned x2 > x3
        tk_ab = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
        tk_ba = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
        pc_next = reset_pc;
        place(u_type(20'h12345, 1, 7'b0110111), 1'b1);        // lui x1
        place(i_type(-7, 0, 3'b000, 2, 7'b0010011), 1'b1);
        place(i_type(5, 0, 3'b000, 3, 7'b0010011), 1'b1);
        place(r_type(7'h00, 3, 2, 3'b000, 4), 1'b1);          // add
        place(r_type(7'h20, 2, 3, 3'b000, 5), 1'b1);          // sub
        place(r_type(7'h00, 3, 3, 3'b001, 6), 1'b1);
        place(r_type(7'h20, 3, 2, 3'b101, 7), 1'b1);          // sra
        place(r_type(7'h00, 3, 2, 3'b101, 8), 1'b1);
        place(r_type(7'h00, 3, 2, 3'b010, 9), 1'b1);
        place(r_type(7'h00, 3, 2, 3'b011, 11), 1'b1);
        place(r_type(7'h00, 2, 1, 3'b100, 12), 1'b1);
        place(r_type(7'h00, 1, 3, 3'b110, 13), 1'b1);
        place(r_type(7'h00, 3, 2, 3'b111, 14), 1'b1);
        p = pc_next;
        place(u_type(20'h00001, 15, 7'b0010111), 1'b1);       // auipc x15
        store_word(1, 'h400, 32'h1234_5000, 1);
        store_word(4, 'h404, 32'hFFFF_FFFE, 1);               // -2
        store_word(5, 'h408, 32'h0000_000C, 1);
        store_word(6, 'h40C, 32'h0000_00A0, 1);
        store_word(7, 'h410, 32'hFFFF_FFFF, 1);               // sign bits shifted in
        store_word(8, 'h414, 32'h07FF_FFFF, 1);
        store_word(9, 'h418, 32'h0000_0001, 1);
        store_word(11, 'h41C, 32'h0000_0000, 1);
        store_word(12, 'h420, 32'hEDCB_AFF9, 1);
        store_word(13, 'h424, 32'h1234_5005, 1);
        store_word(14, 'h428, 32'h0000_0001, 1);
        store_word(15, 'h42C, p + 32'h1000, 1);
        for (int i = 0; i < 6; i++) begin
            branch_case(f3s[i], 2, 3, tk_ab[i]);
            branch_case(f3s[i], 3, 2, tk_ba[i]);
        end
        branch_case(3'b000, 3, 3, 1'b1);
        branch_case(3'b001, 3, 3, 1'b0);
        store_word(20, 'h430, marker, 2);
        p = pc_next;
        place(j_type(8, 21), 1'b1);
        place(i_type(100, 20, 3'b000, 20, 7'b0010011), 1'b0);
        store_word(21, 'h434, p + 4, 2);
        p = pc_next;
        place(u_type(20'h00000, 24, 7'b0010111), 1'b1);
        place(i_type(13, 24, 3'b000, 22, 7'b1100111), 1'b1);  // odd target, bit 0 dropped
        place(i_type(100, 20, 3'b000, 20, 7'b0010011), 1'b0);
        store_word(22, 'h438, p + 8, 2);
        store_word(4, 'h500, 32'hFFFF_FFFE, 3);
        place(i_type('h500, 0, 3'b010, 25, 7'b0000011), 1'b1); // lw x25
        store_word(25, 'h504, 32'hFFFF_FFFE, 3);
        place(i_type(99, 0, 3'b000, 0, 7'b0010011), 1'b1);    // write to x0
        store_word(0, 'h508, 0, 3);
        store_word(20, 'h50C, marker, 2);
        n_exec = fetch_exp.size();
        place(j_type(0, 0), 1'b1);                            // park here
    endtask

    always @(posedge clk)
        rst_d <= reset;

    always @(posedge clk) begin
        if (!reset && retire)
            retire_count++;
        if (!reset && m_axil_req.arvalid)
            seen_ar <= 1'b1;
        if (!reset && m_axil_req.arvalid && m_axil_resp.arready
                && m_axil_req.araddr < 32'h400) begin
            if (fetch_count < fetch_exp.size())
                assert (m_axil_req.araddr == fetch_exp[fetch_count]) else begin
                    $display("Mismatch at %0t: araddr got %h expected %h", $time,
                             m_axil_req.araddr, fetch_exp[fetch_count]);
                    errors[2]++;
                end
            fetch_count++;
        end
    end

    always @(posedge clk) begin
        store_t e;
        if (st_ev) begin
            if (store_exp.size() == 0) begin
                $display("store to %h at %0t was not expected", st_addr, $time);
                errors[4]++;
            end else begin
                e = store_exp.pop_front();
                assert (st_addr == e.addr && st_data == e.data) else begin
                    $display("Mismatch at %0t: store @%h got %h expected %h @%h", $time,
                             st_addr, st_data, e.data, e.addr);
                    errors[e.test]++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the program did not finish", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) (reset || rst_d) |->
        !(m_axil_req.arvalid || m_axil_req.awvalid || m_axil_req.wvalid ||
          m_axil_req.rready || m_axil_req.bready || retire))
        else begin
            $display("bus or retire active around reset at %0t", $time);
            errors[0]++;
        end
    a_first_fetch: assert property (@(posedge clk) disable iff (reset)
        m_axil_req.arvalid && !seen_ar |-> m_axil_req.araddr == reset_pc)
        else begin
            $display("Mismatch at %0t: araddr got %h expected %h", $time,
                     m_axil_req.araddr, reset_pc);
            errors[0]++;
        end
    a_ar_stable: assert property (@(posedge clk) disable iff (reset)
        m_axil_req.arvalid && !m_axil_resp.arready |=>
            m_axil_req.arvalid && $stable(m_axil_req.araddr))
        else begin
            $display("AR changed before its handshake at %0t", $time);
            errors[4]++;
        end
    a_aw_stable: assert property (@(posedge clk) disable iff (reset)
        m_axil_req.awvalid && !m_axil_resp.awready |=>
            m_axil_req.awvalid && $stable(m_axil_req.awaddr))
        else begin
            $display("AW changed before its handshake at %0t", $time);
            errors[4]++;
        end
    a_w_stable: assert property (@(posedge clk) disable iff (reset)
        m_axil_req.wvalid && !m_axil_resp.wready |=>
            m_axil_req.wvalid && $stable(m_axil_req.wdata))
        else begin
            $display("W changed before its handshake at %0t", $time);
            errors[4]++;
        end
    a_wstrb_full: assert property (@(posedge clk) disable iff (reset)
        m_axil_req.wvalid |-> m_axil_req.wstrb == 4'hF)
        else begin
            $display("Mismatch at %0t: wstrb got %h expected %h", $time,
                     m_axil_req.wstrb, 4'hF);
            errors[3]++;
        end
    a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
        !((m_axil_req.arvalid || m_axil_req.rready) &&
          (m_axil_req.awvalid || m_axil_req.wvalid || m_axil_req.bready)))
        else begin
            $display("read and write active together at %0t", $time);
            errors[4]++;
        end

    initial begin
        void'($urandom(39300));
        clk     = 1'b0;
        reset   = 1'b1;
        seen_ar = 1'b0;
        build_program();
        limit = n_exec * 40;
        #1;
        foreach (prog[i])
            mem0.mem[i] = prog[i];
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        while (fetch_count == 0)
            @(negedge clk);
        $display("test %-14s done, %0d errors", names[0], errors[0]);
        while (fetch_count < n_exec + 1)
            @(negedge clk);
        assert (retire_count == n_exec) else begin
            $display("Mismatch at %0t: retire count got %0d expected %0d", $time,
                     retire_count, n_exec);
            errors[4]++;
        end
        assert (store_exp.size() == 0) else begin
            $display("%0d expected stores never happened", store_exp.size());
            errors[4]++;
        end
        for (int i = 1; i < 5; i++)
            $display("test %-14s done, %0d errors", names[i], errors[i]);
        for (int i = 0; i < 5; i++) begin
            total += errors[i];
            if (errors[i] != 0)
                failed++;
        end
        $display("tests 5, failed %0d, errors %0d", failed, total);
        if (total == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verilog.f
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/axil_port.sv
hdl/rv_ctrl.sv
hdl/rv_core.sv
bench/tb_axil_mem.sv
bench/tb_rv_core.sv

//--- Makefile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module tb_rv_core -f verilog.f

sim:
	verilator --binary --timing --assert --top-module tb_rv_core -f verilog.f -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)
	! grep -q "FAIL: see errors above" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
